/* Makefile */
# Verilator build for the system-bus core testbench

VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= *** PASSED ***

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass message shows up in the simulation output
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

/* dv/tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic sysclk
);

    initial sysclk = 1'b0;

    always #10 sysclk = ~sysclk;    // 20 unit period

endmodule

`default_nettype wire

/* dv/tb_top.sv */
`default_nettype none

module tb_top;

    localparam int POLL_LIMIT = 60;     // Status reads before giving up

    logic        sysclk;
    logic        reset;
    logic        rd_n;
    logic        wr_n;
    logic        mreq_n;
    logic        iorq_n;
    logic [15:0] a;
    logic [7:0]  d_in;
    logic [7:0]  d_out;
    logic        d_oe;
    logic [4:0]  ba;
    logic        rom_ce_n;
    logic        ram_ce_n;
    logic        cassette_in;
    logic        cassette_out;
    logic        printer_in;
    logic        printer_out;
    logic [63:0] keys;
    logic        uart_txd;
    logic        uart_cts;
    logic        uart_rts;

    integer seed = 6;
    int     checks;
    int     errors;
    int     test_checks;
    int     test_errors;

    // Reference model
    logic [7:0] bank_m [4];
    logic       cass_m;
    logic       prn_m;
    logic [7:0] rx_q [$];

    // Captured in the middle of each bus access
    logic       smp_rom;
    logic       smp_ram;
    logic [4:0] smp_ba;
    logic       smp_oe;
    logic       smp_txd;

    tb_clock clock_gen (.sysclk(sysclk));

    system_top dut (
        .sysclk       (sysclk),
        .reset        (reset),
        .rd_n         (rd_n),
        .wr_n         (wr_n),
        .mreq_n       (mreq_n),
        .iorq_n       (iorq_n),
        .a            (a),
        .d_in         (d_in),
        .d_out        (d_out),
        .d_oe         (d_oe),
        .ba           (ba),
        .rom_ce_n     (rom_ce_n),
        .ram_ce_n     (ram_ce_n),
        .cassette_in  (cassette_in),
        .cassette_out (cassette_out),
        .printer_in   (printer_in),
        .printer_out  (printer_out),
        .keys         (keys),
        .uart_rxd     (uart_txd),     // Loopback
        .uart_txd     (uart_txd),
        .uart_cts     (uart_cts),
        .uart_rts     (uart_rts)
    );

    ////////////////////
    // Helpers
    ////////////////////

    task automatic compare(input string name, input logic [7:0] got, input logic [7:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s is %02h, expected %02h", $time, name, got, exp);
        end
    endtask

    task automatic end_run();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    endtask

    task automatic test_done(input string name);
        $display("Test %s finished: %0d checks, %0d errors", name,
                 checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    // Strobes low for 5 cycles and idle for 2 after
    task automatic bus_access(input logic io, input logic write, input logic [15:0] addr,
                              input logic [7:0] data, output logic [7:0] rdata);
        @(posedge sysclk);
        a      <= addr;
        d_in   <= data;
        mreq_n <= io;
        iorq_n <= !io;
        wr_n   <= !write;
        rd_n   <= write;
        repeat (4) @(posedge sysclk);
        @(negedge sysclk);
        rdata   = d_out;
        smp_rom = rom_ce_n;
        smp_ram = ram_ce_n;
        smp_ba  = ba;
        smp_oe  = d_oe;
        smp_txd = uart_txd;
        @(posedge sysclk);
        mreq_n <= 1'b1;
        iorq_n <= 1'b1;
        wr_n   <= 1'b1;
        rd_n   <= 1'b1;
        repeat (2) @(posedge sysclk);
    endtask

    task automatic io_write(input logic [15:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        bus_access(1'b1, 1'b1, addr, data, unused);
    endtask

    task automatic io_read(input logic [15:0] addr, output logic [7:0] data);
        bus_access(1'b1, 1'b0, addr, 8'h00, data);
        compare("d_oe", smp_oe, 8'h01);
    endtask

    // Poll the serial status port until one bit reaches a value
    task automatic wait_status(input int bit_idx, input logic value, input string what);
        logic [7:0] st;
        int         polls;
        polls = 0;
        io_read(16'h00F4, st);
        while (st[bit_idx] !== value && polls < POLL_LIMIT) begin
            polls++;
            io_read(16'h00F4, st);
        end
        if (st[bit_idx] !== value) begin
            errors++;
            $display("Timeout at %0t while waiting for %s", $time, what);
            end_run();
        end
    endtask

    // Expected {rom_ce_n, ram_ce_n, ba} of a memory access
    function automatic logic [6:0] decode_model(input logic [15:0] addr, input logic write);
        logic [7:0] bank;
        logic       rom_n;
        logic       ram_n;
        logic [4:0] page_lo;
        bank    = bank_m[addr[15:14]];
        rom_n   = 1'b1;
        ram_n   = 1'b1;
        page_lo = bank[4:0];
        if (bank[6] && addr[15:11] == 5'b00111) begin
            ram_n   = 1'b0;     // System RAM at page 32
            page_lo = 5'd0;
        end else if (!(bank[6] && addr[15:12] == 4'h3) && !(write && bank[7])) begin
            rom_n = bank[5:0] > 6'd15;
            ram_n = bank[5:0] < 6'd32;
        end
        return {rom_n, ram_n, page_lo};
    endfunction

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin
        logic [7:0]  b;
        logic [7:0]  r;
        logic [7:0]  st;
        logic [7:0]  key_exp;
        logic [15:0] addr;
        logic [6:0]  exp;
        logic        exp_oe;
        logic        wr;
        int          k;

        reset       = 1'b1;
        rd_n        = 1'b1;
        wr_n        = 1'b1;
        mreq_n      = 1'b1;
        iorq_n      = 1'b1;
        a           = 16'h0000;
        d_in        = 8'h00;
        cassette_in = 1'b0;
        printer_in  = 1'b0;
        keys        = '1;
        uart_cts    = 1'b1;
        checks      = 0;
        errors      = 0;
        test_checks = 0;
        test_errors = 0;
        bank_m      = '{8'hC0, 8'h21, 8'h22, 8'h13};
        cass_m      = 1'b0;
        prn_m       = 1'b0;

        repeat (5) @(posedge sysclk);
        reset <= 1'b0;

        // Reset state
        @(negedge sysclk);
        compare("cassette_out", cassette_out, 8'h00);
        compare("printer_out", printer_out, 8'h00);
        compare("uart_txd", uart_txd, 8'h01);
        compare("uart_rts", uart_rts, 8'h00);
        compare("d_oe", d_oe, 8'h00);
        compare("rom_ce_n", rom_ce_n, 8'h01);
        compare("ram_ce_n", ram_ce_n, 8'h01);
        for (int i = 0; i < 4; i++) begin
            io_read(16'h00F0 + 16'(i), r);
            compare("d_out", r, bank_m[i]);
        end
        test_done("reset values");

        // Register write and read back
        for (int i = 0; i < 16; i++) begin
            k = {$random(seed)} % 6;
            b = $random(seed);
            if (k < 4) begin
                io_write(16'h00F0 + 16'(k), b);
                bank_m[k] = b;
                io_read(16'h00F0 + 16'(k), r);
                compare("d_out", r, bank_m[k]);
            end else if (k == 4) begin
                io_write(16'h00FC, b);
                cass_m = b[0];
                @(posedge sysclk);
                cassette_in <= b[1];
                @(negedge sysclk);
                compare("cassette_out", cassette_out, cass_m);
                io_read(16'h00FC, r);
                compare("d_out", r, {7'b0, b[1]});
            end else begin
                io_write(16'h00FE, b);
                prn_m = b[0];
                @(posedge sysclk);
                printer_in <= b[1];
                @(negedge sysclk);
                compare("printer_out", printer_out, prn_m);
                io_read(16'h00FE, r);
                compare("d_out", r, {7'b0, b[1]});
            end
        end
        test_done("register read back");

        // Memory decode with writes to a read-only bank in the last 8 rounds
        for (int i = 0; i < 32; i++) begin
            k = $random(seed) & 3;
            b = $random(seed);
            if (i >= 24) b = (b | 8'h80) & 8'hBF;
            io_write(16'h00F0 + 16'(k), b);
            bank_m[k] = b;
            addr = $random(seed);
            wr   = $random(seed) & 1;
            if (i >= 24) begin
                addr[15:14] = k[1:0];
                wr          = 1'b1;
            end else if (($random(seed) & 3) == 0) begin
                addr[15:12] = 4'h3;     // Overlay windows
            end
            bus_access(1'b0, wr, addr, 8'(b + 1), r);
            exp    = decode_model(addr, wr);
            exp_oe = !wr && bank_m[0][6] && addr[15:11] == 5'b00110;  // Internal overlay read
            compare("rom_ce_n", smp_rom, exp[6]);
            compare("ram_ce_n", smp_ram, exp[5]);
            compare("d_oe", smp_oe, {7'b0, exp_oe});
            if (!exp[6] || !exp[5]) compare("ba", smp_ba, exp[4:0]);
        end
        test_done("memory decode");

        // Keyboard matrix
        for (int i = 0; i < 12; i++) begin
            @(posedge sysclk);
            keys <= {$random(seed), $random(seed)};
            addr = {8'($random(seed)), 8'hFF};
            io_read(addr, r);
            key_exp = 8'hFF;
            for (int key = 0; key < 64; key++) begin
                // A pressed key in a selected row pulls its column low
                if (!addr[8 + key / 8] && !keys[key]) key_exp[key % 8] = 1'b0;
            end
            compare("d_out", r, key_exp);
        end
        test_done("keyboard");

        ////////////////////
        // Serial link
        ////////////////////

        for (int i = 0; i < 6; i++) begin
            wait_status(1, 1'b0, "tx_busy to clear");
            b = $random(seed);
            io_write(16'h00F5, b);
            rx_q.push_back(b);
        end
        for (int i = 0; i < 6; i++) begin
            wait_status(0, 1'b1, "received data");
            io_read(16'h00F5, r);
            compare("d_out", r, rx_q.pop_front());
        end
        io_read(16'h00F4, st);
        compare("rx_not_empty", st[0], 8'h00);

        // Frame held off until cts rises
        @(posedge sysclk);
        uart_cts <= 1'b0;
        b = $random(seed);
        io_write(16'h00F5, b);
        rx_q.push_back(b);
        for (int i = 0; i < 8; i++) begin
            io_read(16'h00F4, st);
            compare("tx_busy", st[1], 8'h00);
            compare("uart_txd", smp_txd, 8'h01);
        end
        @(posedge sysclk);
        uart_cts <= 1'b1;
        wait_status(1, 1'b1, "tx_busy after cts rises");
        wait_status(0, 1'b1, "received data");
        io_read(16'h00F5, r);
        compare("d_out", r, rx_q.pop_front());
        test_done("serial loopback");

        // Only the first 16 bytes fit in the FIFO
        for (int i = 0; i < 20; i++) begin
            wait_status(1, 1'b0, "tx_busy to clear");
            b = $random(seed);
            io_write(16'h00F5, b);
            if (i < 16) rx_q.push_back(b);
        end
        wait_status(1, 1'b0, "tx_busy to clear");
        wait_status(4, 1'b1, "overflow flag");
        @(negedge sysclk);
        compare("uart_rts", uart_rts, 8'h01);
        for (int i = 0; i < 16; i++) begin
            io_read(16'h00F4, st);
            compare("rx_not_empty", st[0], 8'h01);
            io_read(16'h00F5, r);
            compare("d_out", r, rx_q.pop_front());
        end
        io_read(16'h00F4, st);
        compare("rx_not_empty", st[0], 8'h00);

        // Break frame and flag clear
        io_write(16'h00F4, 8'h80);
        wait_status(2, 1'b1, "break flag");
        io_read(16'h00F4, st);
        compare("overflow", st[4], 8'h01);
        compare("framing", st[3], 8'h00);
        wait_status(1, 1'b0, "break frame to end");
        io_write(16'h00F4, 8'h1C);
        io_read(16'h00F4, st);
        compare("flags", st[4:2], 8'h00);
        compare("rx_not_empty", st[0], 8'h00);
        test_done("overflow and break");

        end_run();
    end

endmodule

`default_nettype wire

/* rtl/bus_decoder.sv */
`default_nettype none

module bus_decoder (
    input  logic                   sysclk,
    input  logic                   reset,
    input  logic                   rd_n,
    input  logic                   wr_n,
    input  logic                   mreq_n,
    input  logic                   iorq_n,
    input  logic [15:0]            a,
    input  logic [7:0]             d_in,
    output logic [7:0]             d_out,
    output logic                   d_oe,
    output logic [4:0]             ba,
    output logic                   rom_ce_n,
    output logic                   ram_ce_n,
    input  logic                   cassette_in,
    input  logic                   printer_in,
    output logic                   cassette_out,
    output logic                   printer_out,
    input  logic [63:0]            keys,
    output uart_pkg::uart_cmd_t    uart_cmd,
    input  uart_pkg::uart_status_t uart_status
);

    bus_pkg::bank_reg_t bank_r [4];
    bus_pkg::bank_reg_t bank;
    bus_pkg::io_port_e  port;

    logic [2:0] wr_n_r;
    logic [2:0] rd_n_r;
    logic [7:0] wr_data;
    logic       cpm_remap_r;
    logic       pop_pend;
    logic [7:0] io_data;
    logic [7:0] key_data;
    logic       io_hit;

    ////////////////////
    // Strobe sync
    ////////////////////

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            wr_n_r <= 3'b111;
            rd_n_r <= 3'b111;
        end else begin
            wr_n_r <= {wr_n_r[1:0], wr_n};
            rd_n_r <= {rd_n_r[1:0], rd_n};
        end
    end

    always_ff @(posedge sysclk) begin
        if (!wr_n) wr_data <= d_in;     // Last byte seen while wr_n is low
    end

    wire bus_write = wr_n_r[2:1] == 2'b10;
    wire bus_read  = rd_n_r[2:1] == 2'b10;
    wire rd_end    = rd_n_r[2:1] == 2'b01;

    ////////////////////
    // Memory decode
    ////////////////////

    assign bank = bank_r[a[15:14]];

    wire sel_overlay = !mreq_n && bank.overlay && a[15:11] == 5'b00110;   // 3000-37FF
    wire sel_sysram  = !mreq_n && bank.overlay && a[15:11] == 5'b00111;   // 3800-3FFF

    // Blocked for internal windows and for writes to read-only banks
    wire allow_mem = !mreq_n && !sel_overlay && !sel_sysram && (wr_n || !bank.ro);

    assign rom_ce_n = !(allow_mem && bank.page <= bus_pkg::ROM_PAGE_LAST);
    assign ram_ce_n = !((allow_mem && bank.page >= bus_pkg::RAM_PAGE_FIRST) || sel_sysram);
    assign ba       = sel_sysram ? bus_pkg::SYSRAM_PAGE[4:0] : bank.page[4:0];

    ////////////////////
    // I/O decode
    ////////////////////

    assign port = bus_pkg::io_port_e'(a[7:0]);

    // Rows with a low address bit take part in the AND
    always_comb begin
        key_data = 8'hFF;
        for (int row = 0; row < 8; row++) begin
            if (!a[8 + row]) key_data &= keys[row * 8 +: 8];
        end
    end

    always_comb begin
        io_hit  = 1'b1;
        io_data = 8'h00;
        case (port)
            bus_pkg::bank0:     io_data = bank_r[0];
            bus_pkg::bank1:     io_data = bank_r[1];
            bus_pkg::bank2:     io_data = bank_r[2];
            bus_pkg::bank3:     io_data = bank_r[3];
            bus_pkg::esp_ctrl:  io_data = {3'b000, uart_status.overflow, uart_status.framing,
                                           uart_status.rx_break, uart_status.tx_busy,
                                           uart_status.rx_not_empty};
            bus_pkg::esp_data:  io_data = uart_status.rx_data;
            bus_pkg::cassette:  io_data = {7'b0, cassette_in};
            bus_pkg::cpm_remap: io_data = {7'b0, cpm_remap_r};
            bus_pkg::printer:   io_data = {7'b0, printer_in};
            bus_pkg::keyboard:  io_data = key_data;
            default:            io_hit  = 1'b0;
        endcase
    end

    wire sel_io   = !iorq_n && io_hit;
    wire io_write = bus_write && sel_io;

    assign d_out = sel_io ? io_data : 8'h00;    // Overlay window reads zero
    assign d_oe  = !rd_n && (sel_io || sel_overlay);

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            bank_r[0]    <= bus_pkg::BANK0_RESET;
            bank_r[1]    <= bus_pkg::BANK1_RESET;
            bank_r[2]    <= bus_pkg::BANK2_RESET;
            bank_r[3]    <= bus_pkg::BANK3_RESET;
            cassette_out <= 1'b0;
            printer_out  <= 1'b0;
            cpm_remap_r  <= 1'b0;
        end else if (io_write) begin
            case (port)
                bus_pkg::bank0:     bank_r[0]    <= wr_data;
                bus_pkg::bank1:     bank_r[1]    <= wr_data;
                bus_pkg::bank2:     bank_r[2]    <= wr_data;
                bus_pkg::bank3:     bank_r[3]    <= wr_data;
                bus_pkg::cassette:  cassette_out <= wr_data[0];
                bus_pkg::cpm_remap: cpm_remap_r  <= wr_data[0];
                bus_pkg::printer:   printer_out  <= wr_data[0];
                default: ;
            endcase
        end
    end

    // FIFO pop is held back until rd_n rises so the byte stays on the bus
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            pop_pend <= 1'b0;
        end else if (bus_read && sel_io && port == bus_pkg::esp_data) begin
            pop_pend <= 1'b1;
        end else if (rd_end) begin
            pop_pend <= 1'b0;
        end
    end

    assign uart_cmd = '{
        tx_data:     wr_data,
        tx_valid:    io_write && port == bus_pkg::esp_data,
        tx_break:    io_write && port == bus_pkg::esp_ctrl && wr_data[7],
        rx_read:     pop_pend && rd_end,
        clear_flags: (io_write && port == bus_pkg::esp_ctrl) ? wr_data[4:2] : 3'b000
    };

    a_one_chip: assert property (@(posedge sysclk) disable iff (reset)
        !(!rom_ce_n && !ram_ce_n));

endmodule

`default_nettype wire

/* rtl/bus_pkg.sv */
`default_nettype none

package bus_pkg;

    ////////////////////
    // I/O map
    ////////////////////

    // Internal ports, low byte of the I/O address
    typedef enum logic [7:0] {
        bank0     = 8'hF0,
        bank1     = 8'hF1,
        bank2     = 8'hF2,
        bank3     = 8'hF3,
        esp_ctrl  = 8'hF4,    // Serial status and control
        esp_data  = 8'hF5,    // Serial data
        cassette  = 8'hFC,
        cpm_remap = 8'hFD,
        printer   = 8'hFE,
        keyboard  = 8'hFF     // Matrix read
    } io_port_e;

    ////////////////////
    // Memory map
    ////////////////////

    typedef struct packed {
        logic       ro;         // Writes to this window are blocked
        logic       overlay;    // 3000-3FFF served internally
        logic [5:0] page;       // 16 KB page out of 64
    } bank_reg_t;

    localparam bank_reg_t BANK0_RESET = 8'hC0;  // Page 0, read-only, overlay on
    localparam bank_reg_t BANK1_RESET = 8'h21;
    localparam bank_reg_t BANK2_RESET = 8'h22;
    localparam bank_reg_t BANK3_RESET = 8'h13;

    // Page ranges of the external chips
    localparam logic [5:0] ROM_PAGE_LAST  = 6'd15;
    localparam logic [5:0] RAM_PAGE_FIRST = 6'd32;

    // Backs the overlay window at 3800-3FFF
    localparam logic [5:0] SYSRAM_PAGE = 6'd32;

endpackage

`default_nettype wire

/* rtl/esp_uart.sv */
`default_nettype none

module esp_uart (
    input  logic                   sysclk,
    input  logic                   reset,
    input  uart_pkg::uart_cmd_t    uart_cmd,
    output uart_pkg::uart_status_t uart_status,
    input  logic                   uart_rxd,
    input  logic                   uart_cts,
    output logic                   uart_txd,
    output logic                   uart_rts
);

    uart_pkg::uart_state_e tx_state;
    uart_pkg::uart_state_e rx_state;

    logic [uart_pkg::BIT_CNT_W-1:0] tx_cnt;
    logic [uart_pkg::BIT_CNT_W-1:0] rx_cnt;
    logic [3:0] tx_bits;
    logic [2:0] rx_bits;
    logic [7:0] tx_shift;
    logic [7:0] tx_hold;
    logic       tx_pend;
    logic       tx_pend_brk;
    logic [7:0] rx_shift;
    logic [1:0] rxd_sync;
    logic [2:0] flags;          // Overflow, framing, break
    logic [7:0] fifo_head;
    logic       fifo_not_empty;
    logic       fifo_ovf;

    ////////////////////
    // Transmitter
    ////////////////////

    wire tx_idle = tx_state == uart_pkg::st_idle;
    wire tx_tick = tx_cnt == uart_pkg::BIT_LAST;
    wire tx_req  = tx_idle && (uart_cmd.tx_valid || uart_cmd.tx_break);  // Dropped when busy
    wire tx_go   = tx_idle && (tx_req || tx_pend) && uart_cts;
    wire go_brk  = tx_req ? uart_cmd.tx_break : tx_pend_brk;

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            tx_state    <= uart_pkg::st_idle;
            tx_cnt      <= '0;
            tx_bits     <= '0;
            tx_pend     <= 1'b0;
            tx_pend_brk <= 1'b0;
            uart_txd    <= 1'b1;
        end else begin
            tx_cnt <= (tx_idle || tx_tick) ? '0 : tx_cnt + 1'b1;
            case (tx_state)
                uart_pkg::st_idle: begin
                    if (tx_go) begin
                        tx_pend  <= 1'b0;
                        tx_bits  <= '0;
                        uart_txd <= 1'b0;
                        tx_state <= go_brk ? uart_pkg::st_break : uart_pkg::st_start;
                    end else if (tx_req) begin          // Waiting for cts
                        tx_pend     <= 1'b1;
                        tx_pend_brk <= uart_cmd.tx_break;
                    end
                end
                uart_pkg::st_start: if (tx_tick) begin
                    uart_txd <= tx_shift[0];
                    tx_state <= uart_pkg::st_data;
                end
                uart_pkg::st_data: if (tx_tick) begin
                    if (tx_bits == 4'd7) begin
                        uart_txd <= 1'b1;
                        tx_state <= uart_pkg::st_stop;
                    end else begin
                        uart_txd <= tx_shift[1];
                        tx_bits  <= tx_bits + 1'b1;
                    end
                end
                uart_pkg::st_stop: if (tx_tick) tx_state <= uart_pkg::st_idle;
                default: if (tx_tick) begin             // Break
                    if (tx_bits == uart_pkg::BREAK_LAST) begin
                        uart_txd <= 1'b1;
                        tx_state <= uart_pkg::st_idle;
                    end else begin
                        tx_bits <= tx_bits + 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if (tx_req) tx_hold <= uart_cmd.tx_data;
        if (tx_go) begin
            tx_shift <= tx_req ? uart_cmd.tx_data : tx_hold;
        end else if (tx_state == uart_pkg::st_data && tx_tick) begin
            tx_shift <= tx_shift >> 1;  // LSB first
        end
    end

    ////////////////////
    // Receiver
    ////////////////////

    wire rxd    = rxd_sync[1];
    wire rx_mid = (rx_state == uart_pkg::st_start) ? rx_cnt == uart_pkg::HALF_LAST
                                                   : rx_cnt == uart_pkg::BIT_LAST;
    wire stop_smp    = rx_state == uart_pkg::st_stop && rx_mid;
    wire rx_push     = stop_smp && rxd;
    wire framing_evt = stop_smp && !rxd && rx_shift != 8'h00;
    wire break_evt   = stop_smp && !rxd && rx_shift == 8'h00;

    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            rxd_sync <= 2'b11;
            rx_state <= uart_pkg::st_idle;
            rx_cnt   <= '0;
            rx_bits  <= '0;
        end else begin
            rxd_sync <= {rxd_sync[0], uart_rxd};
            rx_cnt   <= (rx_state == uart_pkg::st_idle || rx_state == uart_pkg::st_break ||
                         rx_mid) ? '0 : rx_cnt + 1'b1;
            case (rx_state)
                uart_pkg::st_idle:  if (!rxd) rx_state <= uart_pkg::st_start;
                uart_pkg::st_start: if (rx_mid) begin
                    rx_bits  <= '0;
                    rx_state <= rxd ? uart_pkg::st_idle : uart_pkg::st_data;  // Glitch filter
                end
                uart_pkg::st_data:  if (rx_mid) begin
                    rx_bits <= rx_bits + 1'b1;
                    if (rx_bits == 3'd7) rx_state <= uart_pkg::st_stop;
                end
                uart_pkg::st_stop:  if (rx_mid) begin
                    rx_state <= rxd ? uart_pkg::st_idle : uart_pkg::st_break;
                end
                default: if (rxd) rx_state <= uart_pkg::st_idle;   // Wait for idle line
            endcase
        end
    end

    always_ff @(posedge sysclk) begin
        if (rx_state == uart_pkg::st_data && rx_mid) rx_shift <= {rxd, rx_shift[7:1]};
    end

    uart_rx_fifo rx_fifo (
        .sysclk      (sysclk),
        .reset       (reset),
        .push        (rx_push),
        .push_data   (rx_shift),
        .pop         (uart_cmd.rx_read),
        .head        (fifo_head),
        .not_empty   (fifo_not_empty),
        .almost_full (uart_rts),
        .overflow    (fifo_ovf)
    );

    // Sticky flags, a new event beats a clear
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) flags <= 3'b000;
        else       flags <= {fifo_ovf, framing_evt, break_evt} | (flags & ~uart_cmd.clear_flags);
    end

    assign uart_status = '{
        rx_data:      fifo_head,
        overflow:     flags[2],
        framing:      flags[1],
        rx_break:     flags[0],
        tx_busy:      !tx_idle,
        rx_not_empty: fifo_not_empty
    };

    a_txd_idle: assert property (@(posedge sysclk) disable iff (reset)
        tx_state == uart_pkg::st_idle |-> uart_txd);

endmodule

`default_nettype wire

/* rtl/system_top.sv */
`default_nettype none

module system_top (
    input  logic        sysclk,
    input  logic        reset,

    // Z80 bus
    input  logic        rd_n,
    input  logic        wr_n,
    input  logic        mreq_n,
    input  logic        iorq_n,
    input  logic [15:0] a,
    input  logic [7:0]  d_in,
    output logic [7:0]  d_out,
    output logic        d_oe,

    // External memory
    output logic [4:0]  ba,
    output logic        rom_ce_n,
    output logic        ram_ce_n,

    input  logic        cassette_in,
    output logic        cassette_out,
    input  logic        printer_in,
    output logic        printer_out,
    input  logic [63:0] keys,

    // Link to the companion microcontroller
    input  logic        uart_rxd,
    output logic        uart_txd,
    input  logic        uart_cts,
    output logic        uart_rts
);

    uart_pkg::uart_cmd_t    uart_cmd;
    uart_pkg::uart_status_t uart_status;

    bus_decoder decoder (
        .sysclk       (sysclk),
        .reset        (reset),
        .rd_n         (rd_n),
        .wr_n         (wr_n),
        .mreq_n       (mreq_n),
        .iorq_n       (iorq_n),
        .a            (a),
        .d_in         (d_in),
        .d_out        (d_out),
        .d_oe         (d_oe),
        .ba           (ba),
        .rom_ce_n     (rom_ce_n),
        .ram_ce_n     (ram_ce_n),
        .cassette_in  (cassette_in),
        .printer_in   (printer_in),
        .cassette_out (cassette_out),
        .printer_out  (printer_out),
        .keys         (keys),
        .uart_cmd     (uart_cmd),
        .uart_status  (uart_status)
    );

    esp_uart uart (
        .sysclk      (sysclk),
        .reset       (reset),
        .uart_cmd    (uart_cmd),
        .uart_status (uart_status),
        .uart_rxd    (uart_rxd),
        .uart_cts    (uart_cts),
        .uart_txd    (uart_txd),
        .uart_rts    (uart_rts)
    );

endmodule

`default_nettype wire

/* rtl/uart_pkg.sv */
`default_nettype none

package uart_pkg;

    localparam int BIT_CYCLES = 16;     // sysclk cycles per serial bit
    localparam int BIT_CNT_W  = $clog2(BIT_CYCLES);
    localparam logic [BIT_CNT_W-1:0] BIT_LAST  = BIT_CNT_W'(BIT_CYCLES - 1);
    localparam logic [BIT_CNT_W-1:0] HALF_LAST = BIT_CNT_W'(BIT_CYCLES / 2 - 1);

    localparam logic [3:0] BREAK_LAST = 4'd11;  // 12 bit times of low

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int RTS_FREE   = 4;      // rts once fewer entries than this are free

    // Decoder to serial link, all single-cycle pulses except tx_data
    typedef struct packed {
        logic [7:0] tx_data;
        logic       tx_valid;
        logic       tx_break;
        logic       rx_read;
        logic [2:0] clear_flags;    // Overflow, framing, break
    } uart_cmd_t;

    // Low five bits line up with the status port
    typedef struct packed {
        logic [7:0] rx_data;        // FIFO head
        logic       overflow;
        logic       framing;
        logic       rx_break;
        logic       tx_busy;
        logic       rx_not_empty;
    } uart_status_t;

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_stop,
        st_break
    } uart_state_e;

endpackage

`default_nettype wire

/* rtl/uart_rx_fifo.sv */
`default_nettype none

module uart_rx_fifo (
    input  logic       sysclk,
    input  logic       reset,
    input  logic       push,
    input  logic [7:0] push_data,
    input  logic       pop,
    output logic [7:0] head,
    output logic       not_empty,
    output logic       almost_full,
    output logic       overflow
);

    logic [7:0] mem [uart_pkg::FIFO_DEPTH];
    logic [uart_pkg::FIFO_AW-1:0] wr_ptr;
    logic [uart_pkg::FIFO_AW-1:0] rd_ptr;
    logic [uart_pkg::FIFO_AW:0]   count;

    wire full    = count == uart_pkg::FIFO_DEPTH;
    wire do_push = push && !full;
    wire do_pop  = pop && not_empty;   // Empty pop ignored

    assign not_empty   = count != '0;
    assign almost_full = count > uart_pkg::FIFO_DEPTH - uart_pkg::RTS_FREE;
    assign overflow    = push && full;  // Byte is lost
    assign head        = mem[rd_ptr];

    always_ff @(posedge sysclk) begin
        if (do_push) mem[wr_ptr] <= push_data;
    end

    // Pointers wrap on their own, depth is a power of two
    always_ff @(posedge sysclk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    a_count_max: assert property (@(posedge sysclk) disable iff (reset)
        count <= uart_pkg::FIFO_DEPTH);

endmodule

`default_nettype wire

/* src.f */
rtl/bus_pkg.sv
rtl/uart_pkg.sv
rtl/uart_rx_fifo.sv
rtl/esp_uart.sv
rtl/bus_decoder.sv
rtl/system_top.sv
dv/tb_clock.sv
dv/tb_top.sv
